/* src.f */
hw/ahb_lite_pkg.sv
hw/usb_ep_pkg.sv
hw/ahb_slave_fsm.sv
hw/occupancy_counter.sv
hw/packet_buffer.sv
hw/status_regs.sv
hw/usb_ep_slave.sv
tb/tb_usb_ep_slave.sv

/* Bender.yml */
package:
  name: usb_ep_slave

sources:
  # packages first
  - hw/ahb_lite_pkg.sv
  - hw/usb_ep_pkg.sv
  # design blocks
  - hw/ahb_slave_fsm.sv
  - hw/occupancy_counter.sv
  - hw/packet_buffer.sv
  - hw/status_regs.sv
  - hw/usb_ep_slave.sv
  # testbench
  - target: simulation
    files:
      - tb/tb_usb_ep_slave.sv

/* tb/tb_usb_ep_slave.sv */
`timescale 1ns/1ns

module tb_usb_ep_slave
	import ahb_lite_pkg::*;
	import usb_ep_pkg::*;
();

	localparam int CLK_HALF = 4;
	// about 100 operations of at most four cycles each, with a wide margin
	localparam int CYCLE_LIMIT = 4000;

	logic               clk;
	logic               n_rst;
	logic               hsel;
	logic [ADDR_W-1:0]  haddr;
	logic [1:0]         htrans;
	logic [1:0]         hsize;
	logic               hwrite;
	logic [HDATA_W-1:0] hwdata;
	logic [HDATA_W-1:0] hrdata;
	logic               hready;
	logic               hresp;
	logic               rx_ready;
	logic               rx_active;
	logic               rx_error;
	logic               tx_active;
	logic               tx_error;
	logic               clear;
	logic               reserved;
	logic [PTR_W-1:0]   tx_size;
	logic [PTR_W-1:0]   occupancy;
	logic               get_tx;
	logic [7:0]         tx_data;
	logic               store_rx;
	logic [7:0]         rx_data;

	// reference model of the buffer and the register map
	logic [7:0]         model_q [$];
	logic [PTR_W-1:0]   exp_occ;
	logic [PTR_W-1:0]   exp_tx_size;
	logic [ER_TX:0]     exp_error;
	logic               exp_hready;
	logic               exp_hresp;
	logic [HDATA_W-1:0] exp_rdata;
	logic [7:0]         exp_tx_byte;
	logic               rd_chk;
	logic               tx_chk;
	logic               wr_phase;
	string              test_name;
	int                 cycles = 0;

	always #CLK_HALF clk = ~clk;

	usb_ep_slave uut (
		.clk(clk), .n_rst(n_rst),
		.hsel_i(hsel), .haddr_i(haddr), .htrans_i(htrans), .hsize_i(hsize),
		.hwrite_i(hwrite), .hwdata_i(hwdata),
		.hrdata_o(hrdata), .hready_o(hready), .hresp_o(hresp),
		.rx_data_ready_i(rx_ready), .rx_transfer_active_i(rx_active),
		.rx_error_i(rx_error), .tx_transfer_active_i(tx_active),
		.tx_error_i(tx_error), .clear_i(clear),
		.buffer_reserved_o(reserved), .tx_packet_data_size_o(tx_size),
		.buffer_occupancy_o(occupancy),
		.get_tx_packet_data_i(get_tx), .tx_packet_data_o(tx_data),
		.store_rx_packet_data_i(store_rx), .rx_packet_data_i(rx_data)
	);

	task automatic report_mismatch(input string what, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		$display("mismatch %s %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	a_hready: assert property (@(posedge clk) disable iff (!n_rst) hready == exp_hready)
		else report_mismatch("hready", $sampled(exp_hready), $sampled(hready));
	a_hresp: assert property (@(posedge clk) disable iff (!n_rst) hresp == exp_hresp)
		else report_mismatch("hresp", $sampled(exp_hresp), $sampled(hresp));
	a_occupancy: assert property (@(posedge clk) disable iff (!n_rst) occupancy == exp_occ)
		else report_mismatch("occupancy", $sampled(exp_occ), $sampled(occupancy));
	a_tx_size: assert property (@(posedge clk) disable iff (!n_rst) tx_size == exp_tx_size)
		else report_mismatch("tx size", $sampled(exp_tx_size), $sampled(tx_size));
	a_rdata: assert property (@(posedge clk) disable iff (!n_rst)
		rd_chk |-> hrdata == exp_rdata)
		else report_mismatch("hrdata", $sampled(exp_rdata), $sampled(hrdata));
	a_tx_byte: assert property (@(posedge clk) disable iff (!n_rst)
		tx_chk |-> tx_data == exp_tx_byte)
		else report_mismatch("tx byte", $sampled(exp_tx_byte), $sampled(tx_data));
	a_reserved: assert property (@(posedge clk) disable iff (!n_rst)
		reserved == (exp_occ != '0 || wr_phase))
		else report_mismatch("reserved", $sampled(exp_occ != '0 || wr_phase),
			$sampled(reserved));

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("CHECKS FAILED");
			$fatal(1, "run hung");
		end
	end

	// a push that does not fit is refused whole
	task automatic model_write(input int n, input logic [31:0] data);
		if (model_q.size() + n <= BUF_DEPTH) begin
			for (int k = 0; k < n; k++) begin
				model_q.push_back(data[8*k +: 8]);
			end
		end
		exp_occ = PTR_W'(model_q.size());
	endtask

	task automatic model_read(input int n);
		for (int k = 0; k < n; k++) begin
			if (model_q.size() > 0) begin
				void'(model_q.pop_front());
			end
		end
		exp_occ = PTR_W'(model_q.size());
	endtask

	task automatic model_clear();
		model_q.delete();
		exp_occ = '0;
		exp_error = '0;
		exp_tx_size = '0;
	endtask

	function automatic logic [31:0] expected_read(input logic [ADDR_W-1:0] addr, input int n);
		logic [31:0] v;
		v = '0;
		if (addr <= DATA_LAST) begin
			// little endian, missing bytes read as zero
			for (int k = 0; k < n; k++) begin
				if (k < model_q.size()) begin
					v[8*k +: 8] = model_q[k];
				end
			end
		end else if (addr == A_STATUS) begin
			v[ST_RX_READY] = rx_ready;
			v[ST_RX_ACTIVE] = rx_active;
			v[ST_TX_ACTIVE] = tx_active;
		end else if (addr == A_ERROR) begin
			v[ER_TX:0] = exp_error;
		end else if (addr == A_OCCUPANCY) begin
			v[PTR_W-1:0] = exp_occ;
		end else if (addr == A_TX_SIZE) begin
			v[PTR_W-1:0] = exp_tx_size;
		end
		return v;
	endfunction

	// one single transfer, address phase then data phase
	task automatic bus_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
			input logic [1:0] size, input logic [31:0] wdata, input logic illegal);
		int n;
		n = (size == BYTE) ? 1 : (size == HALF) ? 2 : 4;
		@(posedge clk);
		hsel <= 1'b1;
		haddr <= addr;
		htrans <= NONSEQ;
		hsize <= size;
		hwrite <= wr;
		@(posedge clk);
		hsel <= 1'b0;
		htrans <= IDLE;
		hwdata <= wdata;
		if (illegal) begin
			exp_hready = 1'b0;
			exp_hresp = 1'b1;
		end else if (wr) begin
			wr_phase = 1'b1;
		end else begin
			rd_chk = 1'b1;
			exp_rdata = expected_read(addr, n);
		end
		@(negedge clk);
		while (!hready) begin
			@(negedge clk);
			// error response completes one cycle after the stall
			exp_hready = 1'b1;
		end
		@(posedge clk);
		exp_hready = 1'b1;
		exp_hresp = 1'b0;
		rd_chk = 1'b0;
		wr_phase = 1'b0;
		if (!illegal && wr) begin
			if (addr <= DATA_LAST) begin
				model_write(n, wdata);
			end else if (addr == A_TX_SIZE) begin
				exp_tx_size = wdata[PTR_W-1:0];
			end else if (addr == A_FLUSH && wdata[0]) begin
				model_clear();
			end
		end else if (!illegal && addr <= DATA_LAST) begin
			model_read(n);
		end
	endtask

	task automatic usb_store(input logic [7:0] b);
		@(posedge clk);
		store_rx <= 1'b1;
		rx_data <= b;
		@(posedge clk);
		store_rx <= 1'b0;
		model_write(1, {24'h0, b});
	endtask

	task automatic usb_get();
		@(posedge clk);
		get_tx <= 1'b1;
		tx_chk = 1'b1;
		exp_tx_byte = (model_q.size() > 0) ? model_q[0] : 8'h00;
		@(posedge clk);
		get_tx <= 1'b0;
		tx_chk = 1'b0;
		model_read(1);
	endtask

	task automatic pulse_clear();
		@(posedge clk);
		clear <= 1'b1;
		@(posedge clk);
		clear <= 1'b0;
		model_clear();
	endtask

	task automatic set_status(input logic ready, input logic ractive, input logic tactive);
		@(posedge clk);
		rx_ready <= ready;
		rx_active <= ractive;
		tx_active <= tactive;
	endtask

	task automatic pulse_error(input logic rx, input logic tx);
		@(posedge clk);
		rx_error <= rx;
		tx_error <= tx;
		@(posedge clk);
		rx_error <= 1'b0;
		tx_error <= 1'b0;
		exp_error[ER_RX] = exp_error[ER_RX] | rx;
		exp_error[ER_TX] = exp_error[ER_TX] | tx;
	endtask

	initial begin
		clk = 1'b0;
		n_rst = 1'b0;
		hsel = 1'b0;
		haddr = '0;
		htrans = IDLE;
		hsize = BYTE;
		hwrite = 1'b0;
		hwdata = '0;
		rx_ready = 1'b0;
		rx_active = 1'b0;
		rx_error = 1'b0;
		tx_active = 1'b0;
		tx_error = 1'b0;
		clear = 1'b0;
		get_tx = 1'b0;
		store_rx = 1'b0;
		rx_data = '0;
		model_clear();
		exp_hready = 1'b1;
		exp_hresp = 1'b0;
		exp_rdata = '0;
		exp_tx_byte = '0;
		rd_chk = 1'b0;
		tx_chk = 1'b0;
		wr_phase = 1'b0;
		test_name = "reset";
		void'($urandom(32'hb71ea734));
		repeat (5) @(posedge clk);
		n_rst <= 1'b1;

		test_name = "ahb_write_usb_drain";
		bus_xfer(1'b1, 7'h00, BYTE, $urandom(), 1'b0);
		bus_xfer(1'b1, 7'h01, HALF, $urandom(), 1'b0);
		bus_xfer(1'b1, 7'h3C, WORD, $urandom(), 1'b0);
		// last get finds the buffer empty
		repeat (8) usb_get();

		test_name = "usb_store_ahb_read";
		repeat (7) usb_store(8'($urandom()));
		bus_xfer(1'b0, 7'h00, BYTE, '0, 1'b0);
		bus_xfer(1'b0, 7'h10, HALF, '0, 1'b0);
		bus_xfer(1'b0, A_OCCUPANCY, WORD, '0, 1'b0);
		bus_xfer(1'b0, 7'h20, WORD, '0, 1'b0);

		test_name = "illegal_access";
		repeat (3) usb_store(8'($urandom()));
		bus_xfer(1'b1, A_STATUS, WORD, 32'hFFFF_FFFF, 1'b1);
		bus_xfer(1'b1, 7'h46, BYTE, $urandom(), 1'b1);
		bus_xfer(1'b0, 7'h46, BYTE, '0, 1'b1);
		bus_xfer(1'b1, 7'h50, WORD, 32'h0000_0001, 1'b1);
		bus_xfer(1'b0, 7'h50, WORD, '0, 1'b1);
		bus_xfer(1'b0, A_FLUSH, WORD, '0, 1'b1);
		bus_xfer(1'b0, 7'h00, WORD, '0, 1'b0);

		test_name = "status_and_errors";
		set_status(1'b1, 1'b0, 1'b1);
		bus_xfer(1'b0, A_STATUS, WORD, '0, 1'b0);
		set_status(1'b0, 1'b1, 1'b0);
		bus_xfer(1'b0, A_STATUS, WORD, '0, 1'b0);
		pulse_error(1'b1, 1'b0);
		bus_xfer(1'b0, A_ERROR, WORD, '0, 1'b0);
		pulse_error(1'b0, 1'b1);
		bus_xfer(1'b0, A_ERROR, WORD, '0, 1'b0);
		bus_xfer(1'b0, A_ERROR, BYTE, '0, 1'b0);
		bus_xfer(1'b1, A_TX_SIZE, WORD, 32'h0000_0028, 1'b0);
		bus_xfer(1'b0, A_TX_SIZE, WORD, '0, 1'b0);
		// bit 0 clear, nothing is flushed
		repeat (2) usb_store(8'($urandom()));
		bus_xfer(1'b1, A_FLUSH, WORD, 32'h0000_0002, 1'b0);
		bus_xfer(1'b1, A_FLUSH, WORD, 32'h0000_0001, 1'b0);
		bus_xfer(1'b0, A_ERROR, WORD, '0, 1'b0);
		bus_xfer(1'b0, A_TX_SIZE, WORD, '0, 1'b0);

		test_name = "full_and_overread";
		pulse_clear();
		repeat (16) bus_xfer(1'b1, 7'h00, WORD, $urandom(), 1'b0);
		bus_xfer(1'b1, 7'h00, BYTE, $urandom(), 1'b0);
		usb_store(8'h5A);
		bus_xfer(1'b0, A_OCCUPANCY, WORD, '0, 1'b0);
		repeat (16) bus_xfer(1'b0, 7'h00, WORD, '0, 1'b0);
		usb_store(8'hC3);
		bus_xfer(1'b0, 7'h00, WORD, '0, 1'b0);
		bus_xfer(1'b0, 7'h00, HALF, '0, 1'b0);

		test_name = "clear_and_flush";
		repeat (3) usb_store(8'($urandom()));
		pulse_clear();
		bus_xfer(1'b0, A_OCCUPANCY, WORD, '0, 1'b0);
		bus_xfer(1'b1, 7'h00, WORD, $urandom(), 1'b0);
		bus_xfer(1'b1, A_TX_SIZE, WORD, 32'h0000_0011, 1'b0);
		bus_xfer(1'b1, A_FLUSH, WORD, 32'h0000_0001, 1'b0);
		bus_xfer(1'b0, 7'h00, WORD, '0, 1'b0);
		bus_xfer(1'b0, A_OCCUPANCY, WORD, '0, 1'b0);

		// let the checks of the last edge run
		@(negedge clk);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* hw/usb_ep_slave.sv */
`timescale 1ns/1ns

module usb_ep_slave
	import ahb_lite_pkg::*;
	import usb_ep_pkg::*;
(
	input  logic               clk,
	input  logic               n_rst,
	// ahb-lite slave
	input  logic               hsel_i,
	input  logic [ADDR_W-1:0]  haddr_i,
	input  logic [1:0]         htrans_i,
	input  logic [1:0]         hsize_i,
	input  logic               hwrite_i,
	input  logic [HDATA_W-1:0] hwdata_i,
	output logic [HDATA_W-1:0] hrdata_o,
	output logic               hready_o,
	output logic               hresp_o,
	// protocol controller
	input  logic               rx_data_ready_i,
	input  logic               rx_transfer_active_i,
	input  logic               rx_error_i,
	input  logic               tx_transfer_active_i,
	input  logic               tx_error_i,
	input  logic               clear_i,
	output logic               buffer_reserved_o,
	output logic [PTR_W-1:0]   tx_packet_data_size_o,
	output logic [PTR_W-1:0]   buffer_occupancy_o,
	// usb tx and rx engines
	input  logic               get_tx_packet_data_i,
	output logic [7:0]         tx_packet_data_o,
	input  logic               store_rx_packet_data_i,
	input  logic [7:0]         rx_packet_data_i
);

	slave_state_e       state;
	logic [ADDR_W-1:0]  reg_addr;
	logic [2:0]         rd_bytes;
	logic [2:0]         wr_bytes;
	logic               buffer_wr;
	logic               buffer_rd;
	logic               reg_wr;
	logic               flush;
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [PTR_W-1:0]   occupancy;
	logic               space_ok;
	logic [HDATA_W-1:0] bus_rdata;
	logic [7:0]         tx_byte;
	logic               push;
	logic [2:0]         push_bytes;
	logic               pop;
	logic [2:0]         pop_bytes;
	logic               buf_clear;

	ahb_slave_fsm u_fsm (
		.clk(clk), .n_rst(n_rst),
		.hsel_i(hsel_i), .haddr_i(haddr_i), .htrans_i(htrans_i),
		.hsize_i(hsize_i), .hwrite_i(hwrite_i),
		.state_o(state), .reg_addr_o(reg_addr),
		.rd_bytes_o(rd_bytes), .wr_bytes_o(wr_bytes),
		.buffer_wr_o(buffer_wr), .buffer_rd_o(buffer_rd),
		.reg_wr_o(reg_wr), .flush_o(flush),
		.hready_o(hready_o), .hresp_o(hresp_o)
	);

	occupancy_counter u_occ (
		.clk(clk), .n_rst(n_rst),
		.push_i(push), .push_bytes_i(push_bytes),
		.pop_i(pop), .pop_bytes_i(pop_bytes), .clear_i(buf_clear),
		.wr_ptr_o(wr_ptr), .rd_ptr_o(rd_ptr),
		.occupancy_o(occupancy), .space_ok_o(space_ok)
	);

	packet_buffer u_buf (
		.clk(clk), .n_rst(n_rst),
		.bus_wr_i(buffer_wr), .wr_bytes_i(wr_bytes), .hwdata_i(hwdata_i),
		.bus_rd_i(buffer_rd), .rd_bytes_i(rd_bytes),
		.rx_store_i(store_rx_packet_data_i), .rx_byte_i(rx_packet_data_i),
		.tx_get_i(get_tx_packet_data_i),
		.wr_ptr_i(wr_ptr), .rd_ptr_i(rd_ptr),
		.occupancy_i(occupancy), .space_ok_i(space_ok),
		.bus_rdata_o(bus_rdata), .tx_byte_o(tx_byte),
		.push_o(push), .push_bytes_o(push_bytes),
		.pop_o(pop), .pop_bytes_o(pop_bytes)
	);

	status_regs u_regs (
		.clk(clk), .n_rst(n_rst),
		.state_i(state), .reg_addr_i(reg_addr), .reg_wr_i(reg_wr),
		.flush_i(flush), .hwdata_i(hwdata_i), .bus_rdata_i(bus_rdata),
		.occupancy_i(occupancy),
		.rx_data_ready_i(rx_data_ready_i),
		.rx_transfer_active_i(rx_transfer_active_i),
		.rx_error_i(rx_error_i),
		.tx_transfer_active_i(tx_transfer_active_i),
		.tx_error_i(tx_error_i), .clear_i(clear_i),
		.hrdata_o(hrdata_o), .tx_packet_data_size_o(tx_packet_data_size_o),
		.buffer_reserved_o(buffer_reserved_o), .clear_o(buf_clear)
	);

	assign buffer_occupancy_o = occupancy;
	assign tx_packet_data_o = tx_byte;

endmodule

/* hw/status_regs.sv */
`timescale 1ns/1ns

module status_regs
	import ahb_lite_pkg::*;
	import usb_ep_pkg::*;
(
	input  logic               clk,
	input  logic               n_rst,
	input  slave_state_e       state_i,
	input  logic [ADDR_W-1:0]  reg_addr_i,
	input  logic               reg_wr_i,
	input  logic               flush_i,
	input  logic [HDATA_W-1:0] hwdata_i,
	input  logic [HDATA_W-1:0] bus_rdata_i,
	input  logic [PTR_W-1:0]   occupancy_i,
	input  logic               rx_data_ready_i,
	input  logic               rx_transfer_active_i,
	input  logic               rx_error_i,
	input  logic               tx_transfer_active_i,
	input  logic               tx_error_i,
	input  logic               clear_i,
	output logic [HDATA_W-1:0] hrdata_o,
	output logic [PTR_W-1:0]   tx_packet_data_size_o,
	output logic               buffer_reserved_o,
	output logic               clear_o
);

	logic [ST_TX_ACTIVE:0] status_q;
	logic [ER_TX:0]        error_q;
	logic [PTR_W-1:0]      tx_size_q;
	logic                  flush_hit;

	// only bit 0 of the flush write matters
	assign flush_hit = flush_i && hwdata_i[0];
	assign clear_o = clear_i || flush_hit;

	// live copy of the controller status
	always_ff @(posedge clk) begin
		if (!n_rst) begin
			status_q <= '0;
		end else begin
			status_q[ST_RX_READY] <= rx_data_ready_i;
			status_q[ST_RX_ACTIVE] <= rx_transfer_active_i;
			status_q[ST_TX_ACTIVE] <= tx_transfer_active_i;
		end
	end

	// sticky errors, held until clear or flush
	always_ff @(posedge clk) begin
		if (!n_rst || clear_o) begin
			error_q <= '0;
		end else begin
			error_q[ER_RX] <= error_q[ER_RX] || rx_error_i;
			error_q[ER_TX] <= error_q[ER_TX] || tx_error_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!n_rst || clear_o) begin
			tx_size_q <= '0;
		end else if (reg_wr_i && reg_addr_i == A_TX_SIZE) begin
			tx_size_q <= hwdata_i[PTR_W-1:0];
		end
	end

	assign tx_packet_data_size_o = tx_size_q;
	assign buffer_reserved_o = occupancy_i != '0 || state_i == ST_WRITE;

	// read data mux for the data phase
	always_comb begin
		hrdata_o = '0;
		if (state_i == ST_READ) begin
			if (reg_addr_i <= DATA_LAST) begin
				hrdata_o = bus_rdata_i;
			end else begin
				case (reg_addr_i)
					A_STATUS:    hrdata_o = HDATA_W'(status_q);
					A_ERROR:     hrdata_o = HDATA_W'(error_q);
					A_OCCUPANCY: hrdata_o = HDATA_W'(occupancy_i);
					A_TX_SIZE:   hrdata_o = HDATA_W'(tx_size_q);
					// flush and holes read back zero
					default:     hrdata_o = '0;
				endcase
			end
		end
	end

endmodule

/* hw/packet_buffer.sv */
`timescale 1ns/1ns

module packet_buffer
	import ahb_lite_pkg::*;
	import usb_ep_pkg::*;
(
	input  logic               clk,
	input  logic               n_rst,
	input  logic               bus_wr_i,
	input  logic [2:0]         wr_bytes_i,
	input  logic [HDATA_W-1:0] hwdata_i,
	input  logic               bus_rd_i,
	input  logic [2:0]         rd_bytes_i,
	input  logic               rx_store_i,
	input  logic [7:0]         rx_byte_i,
	input  logic               tx_get_i,
	input  logic [PTR_W-1:0]   wr_ptr_i,
	input  logic [PTR_W-1:0]   rd_ptr_i,
	input  logic [PTR_W-1:0]   occupancy_i,
	input  logic               space_ok_i,
	output logic [HDATA_W-1:0] bus_rdata_o,
	output logic [7:0]         tx_byte_o,
	output logic               push_o,
	output logic [2:0]         push_bytes_o,
	output logic               pop_o,
	output logic [2:0]         pop_bytes_o
);

	logic [7:0]       mem [BUF_DEPTH];
	logic [7:0]       wr_lane [4];
	logic [7:0]       rd_lane [4];
	logic [PTR_W-2:0] wr_idx [4];
	logic [PTR_W-2:0] rd_idx [4];

	// bus side wins, the usb strobe is dropped on a clash
	assign push_o = bus_wr_i || rx_store_i;
	assign push_bytes_o = bus_wr_i ? wr_bytes_i : 3'd1;
	assign pop_o = bus_rd_i || tx_get_i;
	assign pop_bytes_o = bus_rd_i ? rd_bytes_i : 3'd1;

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			wr_idx[k] = wr_ptr_i[PTR_W-2:0] + (PTR_W-1)'(k);
			rd_idx[k] = rd_ptr_i[PTR_W-2:0] + (PTR_W-1)'(k);
			// little endian lanes, a usb store only uses lane 0
			wr_lane[k] = bus_wr_i ? hwdata_i[8*k +: 8] : rx_byte_i;
		end
	end

	always_ff @(posedge clk) begin
		if (push_o && space_ok_i) begin
			for (int k = 0; k < 4; k++) begin
				if (k < push_bytes_o) begin
					mem[wr_idx[k]] <= wr_lane[k];
				end
			end
		end
	end

	// bytes past occupancy read as zero
	always_comb begin
		for (int k = 0; k < 4; k++) begin
			rd_lane[k] = (k < occupancy_i) ? mem[rd_idx[k]] : 8'h00;
		end
	end

	always_comb begin
		bus_rdata_o = '0;
		for (int k = 0; k < 4; k++) begin
			if (k < rd_bytes_i) begin
				bus_rdata_o[8*k +: 8] = rd_lane[k];
			end
		end
	end

	assign tx_byte_o = rd_lane[0];

	// a bus write always carries a byte, half or word count
	a_bus_wr_bytes: assert property (@(posedge clk) disable iff (!n_rst)
		bus_wr_i |-> wr_bytes_i inside {3'd1, 3'd2, 3'd4})
		else $error("bus write with an unsupported byte count");

endmodule

/* hw/occupancy_counter.sv */
`timescale 1ns/1ns

module occupancy_counter
	import usb_ep_pkg::*;
(
	input  logic             clk,
	input  logic             n_rst,
	input  logic             push_i,
	input  logic [2:0]       push_bytes_i,
	input  logic             pop_i,
	input  logic [2:0]       pop_bytes_i,
	input  logic             clear_i,
	output logic [PTR_W-1:0] wr_ptr_o,
	output logic [PTR_W-1:0] rd_ptr_o,
	output logic [PTR_W-1:0] occupancy_o,
	output logic             space_ok_o
);

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W-1:0] push_cnt;
	logic [PTR_W-1:0] pop_req;
	logic [PTR_W-1:0] pop_cnt;

	assign push_cnt = PTR_W'(push_bytes_i);
	assign pop_req = PTR_W'(pop_bytes_i);

	// wrap bit keeps a full buffer apart from an empty one
	assign occupancy_o = wr_ptr_q - rd_ptr_q;

	// whole push must fit, otherwise it is refused
	assign space_ok_o = (occupancy_o + push_cnt) <= BUF_DEPTH;

	// never pop past the write pointer
	assign pop_cnt = (pop_req > occupancy_o) ? occupancy_o : pop_req;

	always_ff @(posedge clk) begin
		if (!n_rst) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else if (clear_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (push_i && space_ok_o) begin
				wr_ptr_q <= wr_ptr_q + push_cnt;
			end
			if (pop_i) begin
				rd_ptr_q <= rd_ptr_q + pop_cnt;
			end
		end
	end

	assign wr_ptr_o = wr_ptr_q;
	assign rd_ptr_o = rd_ptr_q;

	a_occ_bound: assert property (@(posedge clk) disable iff (!n_rst)
		occupancy_o <= BUF_DEPTH)
		else $error("buffer occupancy above depth: %0d", occupancy_o);

endmodule

/* hw/ahb_slave_fsm.sv */
`timescale 1ns/1ns

module ahb_slave_fsm
	import ahb_lite_pkg::*;
	import usb_ep_pkg::*;
(
	input  logic              clk,
	input  logic              n_rst,
	input  logic              hsel_i,
	input  logic [ADDR_W-1:0] haddr_i,
	input  logic [1:0]        htrans_i,
	input  logic [1:0]        hsize_i,
	input  logic              hwrite_i,
	output slave_state_e      state_o,
	output logic [ADDR_W-1:0] reg_addr_o,
	output logic [2:0]        rd_bytes_o,
	output logic [2:0]        wr_bytes_o,
	output logic              buffer_wr_o,
	output logic              buffer_rd_o,
	output logic              reg_wr_o,
	output logic              flush_o,
	output logic              hready_o,
	output logic              hresp_o
);

	slave_state_e      state_q;
	slave_state_e      state_n;
	logic              err_wait_q;
	logic              err_wait_n;
	logic [ADDR_W-1:0] addr_q;
	hsize_e            size_q;
	htrans_e           trans;
	logic              valid;
	logic              illegal;
	logic              in_window;
	logic [2:0]        nbytes;

	assign trans = htrans_e'(htrans_i);
	assign valid = hsel_i && (trans == NONSEQ || trans == SEQ);

	// address phase legality
	always_comb begin
		illegal = 1'b0;
		// writes to the read-only block
		if (hwrite_i && haddr_i >= A_STATUS && haddr_i < A_TX_SIZE) begin
			illegal = 1'b1;
		end
		if (!hwrite_i && haddr_i == A_FLUSH) begin
			illegal = 1'b1;
		end
		// holes between tx size and flush, and the top of the map
		if ((haddr_i > A_TX_SIZE && haddr_i < A_FLUSH) || haddr_i > A_FLUSH) begin
			illegal = 1'b1;
		end
	end

	always_comb begin
		state_n = ST_IDLE;
		err_wait_n = 1'b0;
		if (state_q == ST_ERROR && err_wait_q) begin
			// second error cycle, the pending address phase is dropped
			state_n = ST_ERROR;
		end else if (valid && illegal) begin
			state_n = ST_ERROR;
			err_wait_n = 1'b1;
		end else if (valid && hwrite_i) begin
			state_n = ST_WRITE;
		end else if (valid) begin
			state_n = ST_READ;
		end
	end

	always_ff @(posedge clk) begin
		if (!n_rst) begin
			state_q <= ST_IDLE;
			err_wait_q <= 1'b0;
		end else begin
			state_q <= state_n;
			err_wait_q <= err_wait_n;
		end
	end

	// address and size carried into the data phase
	always_ff @(posedge clk) begin
		if (hready_o) begin
			addr_q <= haddr_i;
			size_q <= hsize_e'(hsize_i);
		end
	end

	always_comb begin
		case (size_q)
			BYTE:    nbytes = 3'd1;
			HALF:    nbytes = 3'd2;
			default: nbytes = 3'd4;
		endcase
	end

	assign in_window = addr_q <= DATA_LAST;

	assign buffer_wr_o = state_q == ST_WRITE && in_window;
	assign buffer_rd_o = state_q == ST_READ && in_window;
	assign reg_wr_o = state_q == ST_WRITE && !in_window;
	assign flush_o = reg_wr_o && addr_q == A_FLUSH;
	assign wr_bytes_o = buffer_wr_o ? nbytes : 3'd0;
	assign rd_bytes_o = buffer_rd_o ? nbytes : 3'd0;
	assign reg_addr_o = addr_q;
	assign state_o = state_q;

	// first error cycle stalls, second one completes
	assign hready_o = !(state_q == ST_ERROR && err_wait_q);
	assign hresp_o = state_q == ST_ERROR;

	// an error response always starts with a stalled cycle
	a_two_cycle_error: assert property (@(posedge clk) disable iff (!n_rst)
		(hresp_o && hready_o) |-> $past(state_q == ST_ERROR && !hready_o))
		else $error("ahb error response completed without a wait cycle");

endmodule

/* hw/usb_ep_pkg.sv */
package usb_ep_pkg;

	// packet buffer geometry
	localparam int BUF_DEPTH = 64;
	// pointer width, one extra bit for wrap
	localparam int PTR_W = 7;

	// haddr width
	localparam int ADDR_W = 7;

	// data window runs from 0x00 up to here
	localparam logic [ADDR_W-1:0] DATA_LAST = 7'h3F;

	// read-only registers
	localparam logic [ADDR_W-1:0] A_STATUS = 7'h40;
	localparam logic [ADDR_W-1:0] A_ERROR = 7'h41;
	localparam logic [ADDR_W-1:0] A_OCCUPANCY = 7'h42;

	// read/write, low byte only
	localparam logic [ADDR_W-1:0] A_TX_SIZE = 7'h44;

	// write-only, bit 0 set flushes the buffer
	localparam logic [ADDR_W-1:0] A_FLUSH = 7'h48;

	// status register bits
	localparam int ST_RX_READY = 0;
	localparam int ST_RX_ACTIVE = 1;
	localparam int ST_TX_ACTIVE = 2;

	// error register bits
	localparam int ER_RX = 0;
	localparam int ER_TX = 1;

endpackage

/* hw/ahb_lite_pkg.sv */
package ahb_lite_pkg;

	// width of hwdata and hrdata
	localparam int HDATA_W = 32;

	// htrans encodings
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	// hsize encodings, code 3 is decoded like WORD
	typedef enum logic [1:0] {
		BYTE = 2'b00,
		HALF = 2'b01,
		WORD = 2'b10
	} hsize_e;

	// data phase type of the slave
	typedef enum logic [1:0] {
		ST_IDLE  = 2'b00,
		ST_READ  = 2'b01,
		ST_WRITE = 2'b10,
		ST_ERROR = 2'b11
	} slave_state_e;

endpackage
